// File: common/mul_pkg.sv
/*
 * Shared definitions for the execute-stage multiply unit
 * Widths, micro-op encoding and the packed val/rdy messages
 */
package mul_pkg;

  // -------------------------------------------------------------------
  // Widths
  // -------------------------------------------------------------------

  localparam int XLEN          = 32;
  localparam int SEQ_NUM_BITS  = 5;
  localparam int REG_ADDR_BITS = 5;

  // Operands carry one extra sign bit inside the multiplier
  localparam int OPX_BITS = XLEN + 1;

  // Split point of the extended op2, low part unsigned
  localparam int SPLIT = 17;

  // 33 x 17 unsigned low part, 33 x 16 signed high part
  localparam int PP_LO_BITS = OPX_BITS + SPLIT;
  localparam int PP_HI_BITS = 2 * OPX_BITS - SPLIT;

  // Full product of two extended operands
  localparam int PROD_BITS = 2 * OPX_BITS;

  // -------------------------------------------------------------------
  // Micro-ops
  // -------------------------------------------------------------------

  typedef enum logic [1:0] {
    MUL    = 2'd0,  // low word
    MULH   = 2'd1,  // signed x signed, high word
    MULHSU = 2'd2,  // signed x unsigned, high word
    MULHU  = 2'd3   // unsigned x unsigned, high word
  } rv_uop;

  // -------------------------------------------------------------------
  // Messages
  // -------------------------------------------------------------------

  // Decode to execute
  typedef struct packed {
    logic [XLEN-1:0]          pc;
    logic [SEQ_NUM_BITS-1:0]  seq_num;
    logic [XLEN-1:0]          op1;
    logic [XLEN-1:0]          op2;
    logic [REG_ADDR_BITS-1:0] waddr;
    rv_uop                    uop;
  } d_x_msg_t;

  // Execute to writeback
  typedef struct packed {
    logic [XLEN-1:0]          pc;
    logic [SEQ_NUM_BITS-1:0]  seq_num;
    logic [REG_ADDR_BITS-1:0] waddr;
    logic [XLEN-1:0]          wdata;
    logic                     wen;
  } x_w_msg_t;

  // Between partial and combine stages
  typedef struct packed {
    logic [XLEN-1:0]          pc;
    logic [SEQ_NUM_BITS-1:0]  seq_num;
    logic [REG_ADDR_BITS-1:0] waddr;
    rv_uop                    uop;
    logic [PP_LO_BITS-1:0]    pp_lo;
    logic [PP_HI_BITS-1:0]    pp_hi;
  } mul_mid_t;

endpackage

// File: list.f
common/mul_pkg.sv
logic/wb_skid_buffer.sv
multiplier/mul_partial_stage.sv
multiplier/mul_combine_stage.sv
multiplier/multiplier_unit.sv
test/multiplier_unit_tb.sv

// File: logic/wb_skid_buffer.sv
/*
 * Two-entry writeback buffer
 * Input ready depends on occupancy only
 */
module wb_skid_buffer
  import mul_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  x_w_msg_t in_msg,
  input  logic     in_val,
  output logic     in_rdy,
  output x_w_msg_t out_msg,
  output logic     out_val,
  input  logic     out_rdy
);

  x_w_msg_t   entries [2];
  logic       rd_ptr;
  logic       wr_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  // Downstream ready never reaches the input side
  assign in_rdy  = (count != 2'd2);
  assign out_val = (count != 2'd0);
  assign out_msg = entries[rd_ptr];

  assign push = in_val && in_rdy;
  assign pop  = out_val && out_rdy;

  // -------------------------------------------------------------------
  // Pointers and occupancy
  // -------------------------------------------------------------------

  // One-bit pointers wrap on their own
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= 1'b0;
      wr_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // Simultaneous push and pop leaves count alone
      if (push && !pop) begin
        count <= count + 2'd1;
      end else if (pop && !push) begin
        count <= count - 2'd1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= in_msg;
    end
  end

endmodule

// File: multiplier/mul_combine_stage.sv
/*
 * Second multiply stage
 * Partial sum, result word select and writeback message
 */
module mul_combine_stage
  import mul_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  mul_mid_t in_msg,
  input  logic     in_val,
  output logic     in_rdy,
  output x_w_msg_t out_msg,
  output logic     out_val,
  input  logic     out_rdy
);

  logic signed [PROD_BITS-1:0] product;
  logic [XLEN-1:0]             result;
  logic                        load;

  x_w_msg_t slot;
  logic     slot_val;

  // -------------------------------------------------------------------
  // Product and result select
  // -------------------------------------------------------------------

  // Both partials sign-extend to the full width before the add
  assign product = $signed(in_msg.pp_lo) + ($signed(in_msg.pp_hi) <<< SPLIT);

  // MUL wants the low word, the MULH family the high word
  always_comb begin
    if (in_msg.uop == MUL) begin
      result = product[XLEN-1:0];
    end else begin
      result = product[2*XLEN-1:XLEN];
    end
  end

  // -------------------------------------------------------------------
  // Register slot
  // -------------------------------------------------------------------

  assign in_rdy = !slot_val || out_rdy;
  assign load   = in_val && in_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_val <= 1'b0;
    end else if (load) begin
      slot_val <= 1'b1;
    end else if (out_rdy) begin
      slot_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      slot.pc      <= in_msg.pc;
      slot.seq_num <= in_msg.seq_num;
      slot.waddr   <= in_msg.waddr;
      slot.wdata   <= result;
      // x0 is never written
      slot.wen     <= |in_msg.waddr;
    end
  end

  assign out_msg = slot;
  assign out_val = slot_val;

endmodule

// File: multiplier/mul_partial_stage.sv
/*
 * First multiply stage
 * Operand extension by micro-op and two registered partial products
 */
module mul_partial_stage
  import mul_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  d_x_msg_t in_msg,
  input  logic     in_val,
  output logic     in_rdy,
  output mul_mid_t out_msg,
  output logic     out_val,
  input  logic     out_rdy
);

  logic                         op1_signed;
  logic                         op2_signed;
  logic [OPX_BITS-1:0]          op1_ext;
  logic [OPX_BITS-1:0]          op2_ext;
  logic signed [PP_LO_BITS-1:0] pp_lo;
  logic signed [PP_HI_BITS-1:0] pp_hi;
  logic                         load;

  mul_mid_t slot;
  logic     slot_val;

  // -------------------------------------------------------------------
  // Operand extension
  // -------------------------------------------------------------------

  // MUL takes the zero-extended path, its low word is the same
  always_comb begin
    op1_signed = (in_msg.uop == MULH) || (in_msg.uop == MULHSU);
    op2_signed = (in_msg.uop == MULH);
    op1_ext    = {op1_signed & in_msg.op1[XLEN-1], in_msg.op1};
    op2_ext    = {op2_signed & in_msg.op2[XLEN-1], in_msg.op2};
  end

  // Low part of op2 is unsigned, hence the zero pad
  assign pp_lo = $signed(op1_ext) * $signed({1'b0, op2_ext[SPLIT-1:0]});

  // High part keeps the sign bit of the extended op2
  assign pp_hi = $signed(op1_ext) * $signed(op2_ext[OPX_BITS-1:SPLIT]);

  // -------------------------------------------------------------------
  // Register slot
  // -------------------------------------------------------------------

  // Free when empty or drained this cycle
  assign in_rdy = !slot_val || out_rdy;
  assign load   = in_val && in_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_val <= 1'b0;
    end else if (load) begin
      slot_val <= 1'b1;
    end else if (out_rdy) begin
      slot_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      slot.pc      <= in_msg.pc;
      slot.seq_num <= in_msg.seq_num;
      slot.waddr   <= in_msg.waddr;
      slot.uop     <= in_msg.uop;
      slot.pp_lo   <= pp_lo;
      slot.pp_hi   <= pp_hi;
    end
  end

  assign out_msg = slot;
  assign out_val = slot_val;

endmodule

// File: multiplier/multiplier_unit.sv
/*
 * Multiply unit top level
 * Partial stage, combine stage and writeback buffer in a chain
 */
module multiplier_unit
  import mul_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  d_x_msg_t d_msg,
  input  logic     d_val,
  output logic     d_rdy,
  output x_w_msg_t w_msg,
  output logic     w_val,
  input  logic     w_rdy
);

  // Stage 1 to stage 2
  mul_mid_t mid_msg;
  logic     mid_val;
  logic     mid_rdy;

  // Stage 2 to buffer
  x_w_msg_t res_msg;
  logic     res_val;
  logic     res_rdy;

  mul_partial_stage u_partial (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_msg  (d_msg),
    .in_val  (d_val),
    .in_rdy  (d_rdy),
    .out_msg (mid_msg),
    .out_val (mid_val),
    .out_rdy (mid_rdy)
  );

  mul_combine_stage u_combine (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_msg  (mid_msg),
    .in_val  (mid_val),
    .in_rdy  (mid_rdy),
    .out_msg (res_msg),
    .out_val (res_val),
    .out_rdy (res_rdy)
  );

  // Cuts the w_rdy path back into the pipeline
  wb_skid_buffer u_wb_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_msg  (res_msg),
    .in_val  (res_val),
    .in_rdy  (res_rdy),
    .out_msg (w_msg),
    .out_val (w_val),
    .out_rdy (w_rdy)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f list.f \
  --top-module multiplier_unit_tb -o mul_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mul_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The testbench prints the fail message on any failure or timeout
if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0

// File: test/mul_trace.txt
# pc seq_num op1 op2 waddr uop expected_wdata expected_wen (all hex)
# uop 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU
00001000 00 00000000 12345678 01 0 00000000 1
00001004 01 00000000 12345678 00 1 00000000 0
00001008 02 00000000 12345678 02 2 00000000 1
0000100c 03 00000000 12345678 1f 3 00000000 1
00001010 04 ffffffff ffffffff 03 0 00000001 1
00001014 05 ffffffff ffffffff 04 1 00000000 1
00001018 06 ffffffff ffffffff 05 2 ffffffff 1
0000101c 07 ffffffff ffffffff 00 3 fffffffe 0
00001020 08 80000000 80000000 06 0 00000000 1
00001024 09 80000000 80000000 07 1 40000000 1
00001028 0a 80000000 80000000 08 2 c0000000 1
0000102c 0b 80000000 80000000 09 3 40000000 1
00001030 0c 80000000 ffffffff 0a 0 80000000 1
00001034 0d 80000000 ffffffff 00 1 00000000 0
00001038 0e 80000000 ffffffff 0b 2 80000000 1
0000103c 0f 80000000 ffffffff 0c 3 7fffffff 1
00001040 10 ffffffff 00000002 0d 0 fffffffe 1
00001044 11 ffffffff 00000002 0e 1 ffffffff 1
00001048 12 ffffffff 00000002 0f 2 ffffffff 1
0000104c 13 ffffffff 00000002 10 3 00000001 1
00001050 14 12345678 00010000 11 0 56780000 1
00001054 15 12345678 00010000 12 1 00001234 1
00001058 16 12345678 00010000 00 2 00001234 0
0000105c 17 12345678 00010000 13 3 00001234 1
00001060 18 fffffffe 7fffffff 14 0 00000002 1
00001064 19 fffffffe 7fffffff 15 1 ffffffff 1
00001068 1a fffffffe 7fffffff 16 2 ffffffff 1
0000106c 1b fffffffe 7fffffff 00 3 7ffffffe 0
00001070 1c 7fffffff 80000000 17 0 80000000 1
00001074 1d 7fffffff 80000000 18 1 c0000000 1
00001078 1e 7fffffff 80000000 19 2 3fffffff 1
0000107c 1f 7fffffff 80000000 1a 3 3fffffff 1

// File: test/multiplier_unit_tb.sv
/*
 * Testbench for the multiply unit
 * Trace loader, driver, writeback checker and watchdog
 */
module multiplier_unit_tb
  import mul_pkg::*;
();

  localparam logic [31:0] SEED = 32'h2910cb3f;

  logic     clk;
  logic     rst_n;
  d_x_msg_t d_msg;
  logic     d_val;
  logic     d_rdy;
  x_w_msg_t w_msg;
  logic     w_val;
  logic     w_rdy;

  // Records and expected results from the trace
  d_x_msg_t        stim [$];
  logic [XLEN-1:0] exp_wdata [$];
  logic            exp_wen [$];
  int              n_rec = 0;
  int              load_err = 0;

  // Checker state
  int          cycle = 0;
  int          acc_cycle [$];
  int          out_idx = 0;
  int          in_flight = 0;
  int          last_out = 0;
  bit          stress = 1'b0;
  int          arith_err = 0;
  int          wen_err = 0;
  int          lat_err = 0;
  int          order_err = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  logic [31:0] gap_rng;
  logic [31:0] rdy_rng;

  multiplier_unit DUT (
    .clk   (clk),
    .rst_n (rst_n),
    .d_msg (d_msg),
    .d_val (d_val),
    .d_rdy (d_rdy),
    .w_msg (w_msg),
    .w_val (w_val),
    .w_rdy (w_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // -------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("Test %s: ok", name);
      tests_passed++;
    end else begin
      $display("Test %s: %0d error(s)", name, errs);
      tests_failed++;
    end
  endtask

  // One record per line and # lines skipped
  task automatic load_trace();
    int          fd;
    string       line;
    d_x_msg_t    rec;
    logic [31:0] f_pc;
    logic [31:0] f_op1;
    logic [31:0] f_op2;
    logic [31:0] f_wdata;
    logic [4:0]  f_seq;
    logic [4:0]  f_waddr;
    logic [1:0]  f_uop;
    logic        f_wen;
    fd = $fopen("test/mul_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file test/mul_trace.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%h %h %h %h %h %h %h %h", f_pc, f_seq, f_op1, f_op2,
                      f_waddr, f_uop, f_wdata, f_wen) == 8) begin
            rec.pc      = f_pc;
            rec.seq_num = f_seq;
            rec.op1     = f_op1;
            rec.op2     = f_op2;
            rec.waddr   = f_waddr;
            rec.uop     = rv_uop'(f_uop);
            stim.push_back(rec);
            exp_wdata.push_back(f_wdata);
            exp_wen.push_back(f_wen);
          end else begin
            $display("Trace line could not be parsed: %s", line);
            load_err++;
          end
        end
      end
      $fclose(fd);
    end
    n_rec = stim.size();
  endtask

  // -------------------------------------------------------------------
  // Driver and random ready
  // -------------------------------------------------------------------

  task automatic run_trace();
    bit taken;
    @(posedge clk);
    #1;
    for (int i = 0; i < n_rec; i++) begin
      // Idle cycle now and then between records
      if (stress && gap_rng[1:0] == 2'b00) begin
        d_val = 1'b0;
        @(posedge clk);
        #1;
      end
      gap_rng = xorshift(gap_rng);
      d_msg   = stim[i];
      d_val   = 1'b1;
      // Held until d_rdy takes it
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = d_rdy;
        if (!taken && !stress) begin
          $display("d_rdy went low during back-to-back input at time %0t", $time);
          lat_err++;
        end
        @(posedge clk);
        #1;
      end
    end
    d_val = 1'b0;
  endtask

  task automatic toggle_w_rdy();
    @(posedge clk);
    #1;
    while (out_idx < n_rec) begin
      rdy_rng = xorshift(rdy_rng);
      w_rdy   = rdy_rng[0];
      @(posedge clk);
      #1;
    end
    w_rdy = 1'b1;
  endtask

  // -------------------------------------------------------------------
  // Monitor
  // -------------------------------------------------------------------

  // Sampled at the falling edge before the rising edge of the transfer
  always @(negedge clk) begin
    if (rst_n) begin
      if (d_val && d_rdy) begin
        acc_cycle.push_back(cycle);
        in_flight++;
      end
      if (w_val && w_rdy) begin
        in_flight--;
        if (out_idx >= n_rec) begin
          $display("Writeback message with no matching record at time %0t", $time);
          order_err++;
        end else begin
          if (w_msg.pc !== stim[out_idx].pc) begin
            $display("FAIL %0t w_msg.pc got %h expected %h",
                     $time, w_msg.pc, stim[out_idx].pc);
            order_err++;
          end
          if (w_msg.seq_num !== stim[out_idx].seq_num) begin
            $display("FAIL %0t w_msg.seq_num got %h expected %h",
                     $time, w_msg.seq_num, stim[out_idx].seq_num);
            order_err++;
          end
          if (w_msg.waddr !== stim[out_idx].waddr) begin
            $display("FAIL %0t w_msg.waddr got %h expected %h",
                     $time, w_msg.waddr, stim[out_idx].waddr);
            order_err++;
          end
          if (w_msg.wdata !== exp_wdata[out_idx]) begin
            $display("FAIL %0t w_msg.wdata got %h expected %h",
                     $time, w_msg.wdata, exp_wdata[out_idx]);
            arith_err++;
          end
          if (w_msg.wen !== exp_wen[out_idx]) begin
            $display("FAIL %0t w_msg.wen got %b expected %b",
                     $time, w_msg.wen, exp_wen[out_idx]);
            wen_err++;
          end
          // Latency and spacing only hold with w_rdy high
          if (!stress) begin
            if (cycle - acc_cycle[out_idx] != 3) begin
              $display("FAIL %0t latency got %0d expected 3",
                       $time, cycle - acc_cycle[out_idx]);
              lat_err++;
            end
            if (out_idx > 0 && cycle != last_out + 1) begin
              $display("Results not on consecutive cycles at time %0t", $time);
              lat_err++;
            end
          end
          last_out = cycle;
          out_idx++;
        end
      end
      if (in_flight > 4) begin
        $display("More than four messages held by the DUT at time %0t", $time);
        order_err++;
      end
    end
  end

  // -------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------

  initial begin
    int reset_err;
    int errs_before;
    rst_n     = 1'b0;
    d_val     = 1'b0;
    d_msg     = '0;
    w_rdy     = 1'b0;
    gap_rng   = SEED;
    rdy_rng   = xorshift(SEED);
    reset_err = 0;
    load_trace();
    report_test("trace load", load_err + ((n_rec == 0) ? 1 : 0));

    // Reset low for 5 cycles and two idle cycles after
    for (int i = 0; i < 7; i++) begin
      @(posedge clk);
      #1;
      if (i == 4) begin
        rst_n = 1'b1;
        w_rdy = 1'b1;
      end
      @(negedge clk);
      if (w_val !== 1'b0) begin
        $display("FAIL %0t w_val got %b expected 0", $time, w_val);
        reset_err++;
      end
      if (d_rdy !== 1'b1) begin
        $display("FAIL %0t d_rdy got %b expected 1", $time, d_rdy);
        reset_err++;
      end
    end
    report_test("reset state", reset_err);

    if (n_rec > 0) begin
      // Back to back with w_rdy high
      run_trace();
      wait (out_idx == n_rec);
      report_test("arithmetic", arith_err);
      report_test("write enable", wen_err);
      report_test("latency and throughput", lat_err);
      report_test("message order", order_err);

      // Same records under input gaps and random w_rdy
      errs_before = arith_err + wen_err + lat_err + order_err;
      out_idx = 0;
      acc_cycle.delete();
      stress = 1'b1;
      fork
        run_trace();
        toggle_w_rdy();
      join
      stress = 1'b0;
      report_test("back-pressure",
                  arith_err + wen_err + lat_err + order_err - errs_before);
    end

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog at 200 cycles per record plus 100
  initial begin
    wait (n_rec > 0);
    #((200 * n_rec + 100) * 10);
    $display("Timeout after %0d cycles, the DUT stopped returning results",
             200 * n_rec + 100);
    $display("Verification failed");
    $finish;
  end

endmodule
